// ==== filelist.f ====
+incdir+verilog
verilog/fmac_pkg.sv
verilog/fmac_ctrl.sv
verilog/fmac_cycle_counter.sv
verilog/fmac_multiplier.sv
verilog/aligner.sv
verilog/fmac_add_normalize.sv
verilog/fmac_top.sv
tb/fmac_checker.sv
tb/fmac_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the FMA testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module fmac_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vfmac_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0

// ==== tb/fmac_tb.sv ====
// Drives fmac_top with table and random exact-integer cases; assumes a 27-cycle fixed latency
`timescale 1ns/1ps

module fmac_tb;

   localparam int clk_period   = 4;
   localparam int reset_cycles = 4;
   localparam int latency      = 27;
   localparam int wait_limit   = 40;
   localparam int num_vec      = 14;
   localparam int num_rand     = 100;
   // Reset check and ignored-start check on top of the operations
   localparam int num_tests    = num_vec + num_rand + 2;

   // One table row, operands and expected result word
   typedef struct packed {
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] exp_res;
   } vec_t;

   logic                     clk;
   logic                     rst;
   logic                     start;
   fmac_pkg::fmac_operands_t ops;
   logic                     busy;
   logic                     done;
   fmac_pkg::fp32_t          result;

   vec_t        vec_tab [num_vec];
   logic [31:0] lcg_state;
   int          err_count;
   int          pass_count;
   int          fail_count;

   fmac_top fmac_top_i (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .ops    (ops),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   bind fmac_top fmac_checker fmac_checker_i (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .busy   (busy),
      .done   (done),
      .result (result)
   );

   always #(clk_period / 2) clk = ~clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Binary32 word of a double, exact only when the value fits in 24 bits
   function automatic logic [31:0] real_to_fp32(input real r);
      logic [63:0] d;
      logic [10:0] e;
      d = $realtobits(r);
      // Rebias from 1023 to 127
      e = d[62:52] - 11'd896;
      if (r == 0.0) begin
         return 32'd0;
      end
      return {d[63], e[7:0], d[51:29]};
   endfunction

   // Signed integer below 2^10 in magnitude, from the upper LCG bits
   task automatic rand_int(output int v);
      int mag;
      lcg_state = lcg_next(lcg_state);
      mag = int'(lcg_state[25:16]);
      v = lcg_state[31] ? -mag : mag;
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                              input string what);
      if (got !== want) begin
         $display("ERROR %0t %s: got %h, expected %h", $time, what, got, want);
         err_count++;
      end
   endtask

   task automatic report_test(input string label, input int errs_before);
      if (err_count == errs_before) begin
         pass_count++;
         $display("%s passed", label);
      end else begin
         fail_count++;
         $display("%s failed", label);
      end
   endtask

   // Counts falling edges until done, sampled mid-cycle
   task automatic wait_done(inout int lat);
      do begin
         @(negedge clk);
         lat++;
      end while (!done && lat < wait_limit);
      if (!done) begin
         $display("no done within %0d cycles of start at time %0t", wait_limit, $time);
         err_count++;
      end
   endtask

   // Start pulse one edge before the DUT samples it
   task automatic run_op(input logic [31:0] a, b, c, output logic [31:0] res, output int lat);
      @(posedge clk);
      ops   <= {a, b, c};
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      lat = 0;
      wait_done(lat);
      res = result;
   endtask

   task automatic apply_case(input string label, input logic [31:0] a, b, c, want);
      logic [31:0] res;
      int          lat;
      int          errs_before;
      errs_before = err_count;
      run_op(a, b, c, res, lat);
      check_value(32'(lat), 32'(latency), {label, " latency"});
      check_value(res, want, {label, " result"});
      report_test(label, errs_before);
   endtask

   task automatic check_reset();
      int errs_before;
      errs_before = err_count;
      @(negedge clk);
      check_value(32'(busy), 32'd0, "busy after reset");
      check_value(32'(done), 32'd0, "done after reset");
      check_value(result, 32'd0, "result after reset");
      report_test("reset", errs_before);
   endtask

   // Second start while busy must be dropped, with no second done
   task automatic check_ignored_start();
      int lat;
      int extra;
      int errs_before;
      errs_before = err_count;
      extra = 0;
      @(posedge clk);
      ops   <= {32'h3F80_0000, 32'h4040_0000, 32'h40A0_0000};
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      repeat (5) @(posedge clk);
      ops   <= {32'h4000_0000, 32'h4000_0000, 32'h4000_0000};
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      // Six edges already gone since the accepted start
      lat = 6;
      wait_done(lat);
      check_value(32'(lat), 32'(latency), "ignored start latency");
      check_value(result, 32'h4180_0000, "ignored start result");
      repeat (30) begin
         @(negedge clk);
         extra += int'(done);
      end
      check_value(32'(extra), 32'd0, "extra done count");
      report_test("ignored start", errs_before);
   endtask

   ////////////////////////////////////////
   // Vector table
   ////////////////////////////////////////

   task automatic fill_table();
      // Product dominates, addend dropping out, equal negative signs
      vec_tab[0]  = {32'h3F80_0000, 32'h4040_0000, 32'h40A0_0000, 32'h4180_0000};
      vec_tab[1]  = {32'h2180_0000, 32'h4000_0000, 32'h4040_0000, 32'h40C0_0000};
      vec_tab[2]  = {32'hBF80_0000, 32'hC040_0000, 32'h40A0_0000, 32'hC180_0000};
      // Addend dominates, truncation both ways
      vec_tab[3]  = {32'h5380_0000, 32'h3F80_0000, 32'h3F80_0000, 32'h5380_0000};
      vec_tab[4]  = {32'h5380_0000, 32'hBF80_0000, 32'h3F80_0000, 32'h537F_FFFF};
      vec_tab[5]  = {32'h4480_0000, 32'h3F00_0000, 32'h3F00_0000, 32'h4480_0800};
      // Effective subtraction
      vec_tab[6]  = {32'h4120_0000, 32'hC000_0000, 32'h4040_0000, 32'h4080_0000};
      vec_tab[7]  = {32'h40C0_0000, 32'hC000_0000, 32'h4040_0000, 32'h0000_0000};
      vec_tab[8]  = {32'h3F80_0000, 32'h4080_0000, 32'hC080_0000, 32'hC170_0000};
      vec_tab[13] = {32'h42C8_0000, 32'hC040_0000, 32'h4204_0000, 32'h3F80_0000};
      // Zero operands
      vec_tab[9]  = {32'h4040_0000, 32'h0000_0000, 32'h40A0_0000, 32'h4040_0000};
      vec_tab[10] = {32'hC0F0_0000, 32'h4000_0000, 32'h0000_0000, 32'hC0F0_0000};
      vec_tab[11] = {32'h0000_0000, 32'h4040_0000, 32'h40A0_0000, 32'h4170_0000};
      vec_tab[12] = {32'h0000_0000, 32'hC000_0000, 32'h4060_0000, 32'hC0E0_0000};
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      int          ia;
      int          ib;
      int          ic;
      logic [31:0] want;
      clk        = 1'b0;
      rst        = 1'b1;
      start      = 1'b0;
      ops        = '0;
      err_count  = 0;
      pass_count = 0;
      fail_count = 0;
      lcg_state  = 32'haa5c_dbfa;
      fill_table();
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      check_reset();
      for (int i = 0; i < num_vec; i++) begin
         apply_case($sformatf("vector %0d", i), vec_tab[i].a, vec_tab[i].b, vec_tab[i].c,
                    vec_tab[i].exp_res);
      end
      check_ignored_start();
      // Sums stay below 2^21, so every result is exact in binary32
      for (int i = 0; i < num_rand; i++) begin
         rand_int(ia);
         rand_int(ib);
         rand_int(ic);
         want = real_to_fp32($itor(ia + ib * ic));
         apply_case($sformatf("random %0d (%0d + %0d * %0d)", i, ia, ib, ic),
                    real_to_fp32($itor(ia)), real_to_fp32($itor(ib)),
                    real_to_fp32($itor(ic)), want);
      end
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog, 40 cycles per test plus reset
   initial begin
      #((reset_cycles + num_tests * wait_limit) * clk_period);
      $display("run timed out before all tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== tb/fmac_checker.sv ====
// Assumes one operation in flight and a fixed 27-cycle start-to-done latency; reset is synchronous
`timescale 1ns/1ps

module fmac_checker (
   input logic            clk,
   input logic            rst,
   input logic            start,
   input logic            busy,
   input logic            done,
   input fmac_pkg::fp32_t result
);

   // Edges from the start sample to the done sample
   localparam int latency = 27;

   ////////////////////////////////////////
   // Start/busy/done protocol
   ////////////////////////////////////////

   // Done is a one-cycle pulse
   done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done stayed high for more than one cycle");

   // Done exactly when a start was accepted 27 cycles back, and never otherwise
   done_latency: assert property (@(posedge clk) disable iff (rst)
      done == $past(start && !busy, latency))
      else $error("done does not line up with an accepted start");

   // Idle unit stays idle until a start comes
   idle_hold: assert property (@(posedge clk) disable iff (rst) (!busy && !start) |=> !busy)
      else $error("busy rose without a start");

   // Result register holds the old value during an operation
   result_hold: assert property (@(posedge clk) disable iff (rst) busy |-> $stable(result))
      else $error("result changed while busy");

endmodule

// ==== verilog/fmac_top.sv ====
// a + b*c in 27 cycles, one operation in flight; result holds until the next done
`timescale 1ns/1ps
`include "fmac_settings.svh"

module fmac_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  fmac_pkg::fmac_operands_t  ops,
   output logic                      busy,
   output logic                      done,
   output fmac_pkg::fp32_t           result
);

   fmac_pkg::fmac_operands_t ops_q;
   fmac_pkg::pp_vec_t        pp;
   fmac_pkg::aligned_t       aligned;

   logic load_ops;
   logic mul_load;
   logic mul_step;
   logic align_capture;
   logic add_capture;
   logic last_step;

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////

   fmac_ctrl fmac_ctrl_i (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .last_step     (last_step),
      .load_ops      (load_ops),
      .mul_load      (mul_load),
      .mul_step      (mul_step),
      .align_capture (align_capture),
      .add_capture   (add_capture),
      .busy          (busy),
      .done          (done)
   );

   fmac_cycle_counter fmac_cycle_counter_i (
      .clk       (clk),
      .rst       (rst),
      .load      (mul_load),
      .step      (mul_step),
      .last_step (last_step)
   );

   // Operands held for the aligner
   always_ff @(posedge clk) begin
      if (load_ops) ops_q <= ops;
   end

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////

   // Loaded in the same cycle as ops_q, so fed straight from the port
   fmac_multiplier fmac_multiplier_i (
      .clk    (clk),
      .rst    (rst),
      .load   (mul_load),
      .step   (mul_step),
      .mant_b ({|ops.b.exp, ops.b.mant}),
      .mant_c ({|ops.c.exp, ops.c.mant}),
      .pp     (pp)
   );

   aligner aligner_i (
      .ops     (ops_q),
      .pp      (pp),
      .aligned (aligned)
   );

   fmac_add_normalize fmac_add_normalize_i (
      .clk         (clk),
      .rst         (rst),
      .capture_in  (align_capture),
      .capture_out (add_capture),
      .aligned     (aligned),
      .result      (result)
   );

endmodule

// ==== verilog/fmac_add_normalize.sv ====
// Truncating adder and normalizer; exponent underflow flushes to +0, overflow wraps unflagged
`timescale 1ns/1ps
`include "fmac_settings.svh"

module fmac_add_normalize (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 capture_in,
   input  logic                 capture_out,
   input  fmac_pkg::aligned_t   aligned,
   output fmac_pkg::fp32_t      result
);

   localparam int aw    = `FMAC_ALIGN_W;
   localparam int win_w = `FMAC_ALIGN_W - 1;
   localparam int ew    = `FMAC_EXP_W + 2;

   fmac_pkg::aligned_t al_q;
   fmac_pkg::fp32_t    res_d;
   logic [aw-1:0]      adj;
   logic [aw-1:0]      total;
   logic [win_w-1:0]   mag;
   logic [win_w-1:0]   norm;
   logic [6:0]         lz;
   logic [ew-1:0]      exp_norm;
   logic               prod_below;
   logic               neg;
   logic               zero_res;

   // Position of the leading one, 74 when v is zero
   function automatic logic [6:0] count_lz(input logic [win_w-1:0] v);
      logic [6:0] n;
      n = 7'(win_w);
      // Highest set bit is seen last
      for (int i = 0; i < win_w; i++) begin
         if (v[i]) n = 7'(win_w - 1 - i);
      end
      return n;
   endfunction

   always_ff @(posedge clk) begin
      if (capture_in) al_q <= aligned;
   end

   ////////////////////////////////////////
   // Three-input add
   ////////////////////////////////////////

   // Product sits shift_under_a places under a; only its borrow survives truncation
   assign prod_below = !al_q.zero_product && (al_q.shift_under_a != '0);

   // Carry-in for the inverted addend, or minus one for a product hidden below a
   assign adj = al_q.a_dominant ? {aw{al_q.sub && prod_below}} : aw'(al_q.sub);

   assign total = aw'(al_q.sum) + aw'(al_q.carry) + al_q.addend + adj;

   // Negative total means the addend won a subtraction
   assign neg = total[aw-1];
   assign mag = neg ? win_w'(~total + 1'b1) : total[win_w-1:0];

   ////////////////////////////////////////
   // Normalize and pack
   ////////////////////////////////////////

   assign lz       = count_lz(mag);
   assign norm     = mag << lz;
   assign exp_norm = al_q.exp - ew'(lz);
   // Zero magnitude and underflow both give +0
   assign zero_res = (mag == '0) || $signed(exp_norm) <= 0;

   assign res_d.sign = zero_res ? 1'b0 : (al_q.sign ^ neg);
   assign res_d.exp  = zero_res ? '0 : exp_norm[`FMAC_EXP_W-1:0];
   // Bits under the leading one, the rest are cut off
   assign res_d.mant = zero_res ? '0 : norm[win_w-2 -: `FMAC_MANT_W];

   always_ff @(posedge clk) begin
      if (rst) begin
         result <= '0;
      end else if (capture_out) begin
         result <= res_d;
      end
   end

endmodule

// ==== verilog/aligner.sv ====
// Normal operands only; a zero exponent field reads as zero, no NaN, infinity or overflow handling
`timescale 1ns/1ps
`include "fmac_settings.svh"

module aligner (
   input  fmac_pkg::fmac_operands_t ops,
   input  fmac_pkg::pp_vec_t        pp,
   output fmac_pkg::aligned_t       aligned
);

   localparam int ew      = `FMAC_EXP_W + 2;
   localparam int win_w   = `FMAC_ALIGN_W - 1;
   localparam int mw      = `FMAC_MANT_W + 1;
   localparam int win_ofs = 27;

   logic [ew-1:0]    sft_amt;
   logic             sft_neg;
   logic             a_zero;
   logic             zero_product;
   logic             a_dom;
   logic             drop;
   logic [mw-1:0]    mant_a_h;
   logic [win_w-1:0] window;
   logic [mw-1:0]    tail_bits;
   logic [win_w-1:0] window_sel;
   logic             tail;
   logic [win_w-1:0] win_sub;

   ////////////////////////////////////////
   // Shift amount and case select
   ////////////////////////////////////////

   assign a_zero       = (ops.a.exp == '0);
   assign zero_product = (ops.b.exp == '0) || (ops.c.exp == '0);
   assign mant_a_h     = a_zero ? '0 : {1'b1, ops.a.mant};

   // Addend MSB sits 27 places above the product MSB at zero shift
   assign sft_amt = ew'(ops.b.exp) + ew'(ops.c.exp) - ew'(ops.a.exp) - ew'(`FMAC_BIAS)
                    + ew'(win_ofs);
   assign sft_neg = sft_amt[ew-1];

   // b*c below a, or nothing to add to a
   assign a_dom = zero_product || (!a_zero && sft_neg);
   // Addend fully under the product LSB
   assign drop  = a_zero || (!sft_neg && (sft_amt > ew'(win_w)));

   ////////////////////////////////////////
   // Addend alignment
   ////////////////////////////////////////

   assign {window, tail_bits} = {mant_a_h, {win_w{1'b0}}} >> (drop ? 7'd0 : sft_amt[6:0]);
   assign window_sel = drop ? '0 : window;
   // Any addend bit below the window
   assign tail       = drop ? (|mant_a_h) : (|tail_bits);

   // Under subtraction a lost tail counts as one more unit, keeping truncation toward zero
   assign win_sub = window_sel + win_w'(tail);

   assign aligned.sub    = ops.a.sign ^ ops.b.sign ^ ops.c.sign;
   assign aligned.addend = a_dom       ? {1'b0, mant_a_h, {(win_w - mw){1'b0}}} :
                           aligned.sub ? {1'b1, ~win_sub} :
                                         {1'b0, window_sel};

   // Exponent of window bit 73
   assign aligned.exp = a_dom ? ew'(ops.a.exp)
                              : ew'(ops.b.exp) + ew'(ops.c.exp) - ew'(`FMAC_BIAS)
                                + ew'(win_ofs);
   assign aligned.sign = a_dom ? ops.a.sign : (ops.b.sign ^ ops.c.sign);

   assign aligned.a_dominant    = a_dom;
   // Distance of the product below the window in the a-dominant case
   assign aligned.shift_under_a = ew'(ops.a.exp) - ew'(ops.b.exp) - ew'(ops.c.exp)
                                  + ew'(`FMAC_BIAS) - ew'(win_ofs);
   assign aligned.zero_product  = zero_product;

   // Product drops out under a
   assign aligned.sum   = a_dom ? '0 : pp.sum;
   assign aligned.carry = a_dom ? '0 : pp.carry;

endmodule

// ==== verilog/fmac_multiplier.sv ====
// Unsigned 24x24 carry-save multiply; sum+carry equals the product only after all 24 steps
`timescale 1ns/1ps
`include "fmac_settings.svh"

module fmac_multiplier (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    load,
   input  logic                    step,
   input  logic [`FMAC_MANT_W:0]   mant_b,
   input  logic [`FMAC_MANT_W:0]   mant_c,
   output fmac_pkg::pp_vec_t       pp
);

   localparam int pw = `FMAC_PROD_W;

   logic [pw-1:0]          mcand_q;    // multiplicand, moves up one place per step
   logic [`FMAC_MANT_W:0]  mplier_q;   // multiplier, consumed from bit 0
   logic [pw-1:0]          sum_q;
   logic [pw-1:0]          carry_q;
   logic [pw-1:0]          pp_row;
   logic [pw-1:0]          sum_d;
   logic [pw-2:0]          maj;

   ////////////////////////////////////////
   // 3:2 compressor
   ////////////////////////////////////////

   // Gated partial product for this step
   assign pp_row = mplier_q[0] ? mcand_q : '0;
   assign sum_d  = sum_q ^ carry_q ^ pp_row;
   // Majority out of the top bit is always zero since the partial sum stays below 2^48
   assign maj    = (sum_q[pw-2:0] & carry_q[pw-2:0]) |
                   (sum_q[pw-2:0] & pp_row[pw-2:0]) |
                   (carry_q[pw-2:0] & pp_row[pw-2:0]);

   always_ff @(posedge clk) begin
      if (rst) begin
         mcand_q  <= '0;
         mplier_q <= '0;
         sum_q    <= '0;
         carry_q  <= '0;
      end else if (load) begin
         mcand_q  <= pw'(mant_c);
         mplier_q <= mant_b;
         sum_q    <= '0;
         carry_q  <= '0;
      end else if (step) begin
         mcand_q  <= {mcand_q[pw-2:0], 1'b0};
         mplier_q <= {1'b0, mplier_q[`FMAC_MANT_W:1]};
         sum_q    <= sum_d;
         // Carries weigh one place more
         carry_q  <= {maj, 1'b0};
      end
   end

   // Left redundant, the adder stage resolves it
   assign pp.sum   = sum_q;
   assign pp.carry = carry_q;

endmodule

// ==== verilog/fmac_cycle_counter.sv ====
// Counts FMAC_MUL_CYCLES steps; a step without a prior load wraps and is not flagged
`timescale 1ns/1ps
`include "fmac_settings.svh"

module fmac_cycle_counter (
   input  logic clk,
   input  logic rst,
   input  logic load,
   input  logic step,
   output logic last_step
);

   localparam int cnt_w = $clog2(`FMAC_MUL_CYCLES);
   localparam logic [cnt_w-1:0] load_val = cnt_w'(`FMAC_MUL_CYCLES - 1);

   logic [cnt_w-1:0] count;

   // Load wins over step
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (load) begin
         count <= load_val;
      end else if (step) begin
         count <= count - 1'b1;
      end
   end

   // Zero means the step now in progress is the last one
   assign last_step = (count == '0);

endmodule

// ==== verilog/fmac_ctrl.sv ====
// One operation at a time; start is ignored unless idle, done is a single-cycle pulse
`timescale 1ns/1ps

module fmac_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic last_step,
   output logic load_ops,
   output logic mul_load,
   output logic mul_step,
   output logic align_capture,
   output logic add_capture,
   output logic busy,
   output logic done
);

   fmac_pkg::fmac_state_t state;
   fmac_pkg::fmac_state_t state_nxt;

   // Next-state logic
   always_comb begin
      state_nxt = state;
      case (state)
         fmac_pkg::IDLE:  if (start) state_nxt = fmac_pkg::MUL;
         // Stay until the counter flags the final iteration
         fmac_pkg::MUL:   if (last_step) state_nxt = fmac_pkg::ALIGN;
         fmac_pkg::ALIGN: state_nxt = fmac_pkg::ADD;
         fmac_pkg::ADD:   state_nxt = fmac_pkg::IDLE;
         default:         state_nxt = fmac_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= fmac_pkg::IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_nxt;
         // Result is written on leaving ADD, so done lines up with it
         done  <= (state == fmac_pkg::ADD);
      end
   end

   // Strobes decoded from the state
   assign load_ops      = (state == fmac_pkg::IDLE) && start;
   assign mul_load      = load_ops;
   assign mul_step      = (state == fmac_pkg::MUL);
   assign align_capture = (state == fmac_pkg::ALIGN);
   assign add_capture   = (state == fmac_pkg::ADD);
   assign busy          = (state != fmac_pkg::IDLE);

endmodule

// ==== verilog/fmac_pkg.sv ====
// Types shared by the FMA data path and its testbench; sizes come from the settings header
`include "fmac_settings.svh"

package fmac_pkg;

   // IEEE-754 binary32 word, fields in storage order
   typedef struct packed {
      logic                    sign;
      logic [`FMAC_EXP_W-1:0]  exp;
      logic [`FMAC_MANT_W-1:0] mant;
   } fp32_t;

   // Operand triple for a + b*c
   typedef struct packed {
      fp32_t a;
      fp32_t b;
      fp32_t c;
   } fmac_operands_t;

   // Redundant product, sum and carry rows
   typedef struct packed {
      logic [`FMAC_PROD_W-1:0] sum;
      logic [`FMAC_PROD_W-1:0] carry;
   } pp_vec_t;

   // Aligner result, handed to the adder stage
   typedef struct packed {
      logic                     sub;
      logic [`FMAC_ALIGN_W-1:0] addend;
      logic [`FMAC_EXP_W+1:0]   exp;            // signed, bit 73 of the window
      logic                     sign;
      logic                     a_dominant;     // product lies below a
      logic [`FMAC_EXP_W+1:0]   shift_under_a;
      logic                     zero_product;
      logic [`FMAC_PROD_W-1:0]  sum;
      logic [`FMAC_PROD_W-1:0]  carry;
   } aligned_t;

   // Sequencer states
   typedef enum logic [1:0] {
      IDLE,
      MUL,
      ALIGN,
      ADD
   } fmac_state_t;

endpackage

// ==== verilog/fmac_settings.svh ====
// Single-precision binary32 only; widths here are fixed and are not checked against each other
`ifndef FMAC_SETTINGS_SVH
`define FMAC_SETTINGS_SVH

////////////////////////////////////////
// Floating-point format
////////////////////////////////////////

// Exponent field width
`define FMAC_EXP_W 8
// Stored mantissa width, hidden bit not counted
`define FMAC_MANT_W 23
// Exponent bias
`define FMAC_BIAS 127

////////////////////////////////////////
// Data path sizes
////////////////////////////////////////

// Two 24-bit mantissas multiplied
`define FMAC_PROD_W 48
// Sign extension bit plus the 74-bit alignment window
`define FMAC_ALIGN_W 75
// One carry-save iteration per multiplier bit
`define FMAC_MUL_CYCLES 24

`endif
